//--- include/irBoard_consts.svh
`ifndef IRBOARD_CONSTS_SVH
`define IRBOARD_CONSTS_SVH

// Datapath and instruction field widths
`define IR_AD_WIDTH     36
`define IR_FIELD_WIDTH  13

// Dispatch RAM geometry
`define DRAM_ADDR_BITS  9
`define DRAM_WIDTH      15
`define DRAM_SIZE       512

// JRST opcode, octal 254
`define JRST_OPCODE     9'o254

// APB register map
`define APB_ADDR_WIDTH  12
`define REG_CTRL        12'h000
`define REG_DIAG_BASE   12'h004
`define DIAG_GROUPS     8

// Address bit that opens the dispatch RAM window, entry in paddr[10:2]
`define DRAM_WINDOW_BIT 11

`endif

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module irBoard_tb -o simv

simOut=$(./obj_dir/simv)
echo "$simOut"

if echo "$simOut" | grep -q "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi

//--- src.f
+incdir+include
src/irBoard_pkg.sv
src/irLatch.sv
src/dispatchRam.sv
src/condTest.sv
src/diagApb.sv
src/irBoard.sv
tb/irBoard_sva.sv
tb/irBoard_tb.sv

//--- src/condTest.sv
`timescale 1ns/100ps
`default_nettype none

module condTest (
  input  wire irBoard_pkg::adWord_t ad,
  input  wire logic                adCarryM2,
  input  wire logic [1:0]          magic,
  input  wire logic [2:0]          dispB,
  output logic                     testSatisfied,
  output logic                     adZero,
  output irBoard_pkg::normCode_t   norm
);

  logic eqTerm;
  logic gtTerm;
  logic ltTerm;
  logic cryTerm;

  assign adZero = ~|ad;

  // Skip and jump conditions selected by the B field
  assign eqTerm  = dispB[1] & adZero;
  assign gtTerm  = dispB[2] & magic[0] & ~ad[0] & ~adZero;
  assign ltTerm  = dispB[2] & magic[1] & ad[0];
  assign cryTerm = (magic[0] ^ magic[1]) & adCarryM2;

  // B bit 0 inverts the sense
  assign testSatisfied = (eqTerm | gtTerm | ltTerm | cryTerm) ^ dispB[0];

  // Normalize priority, sign bit first
  always_comb begin
    if (ad[0]) begin
      norm = 3'd1;
    end else if (|ad[1:6]) begin
      norm = 3'd2;
    end else if (ad[7]) begin
      norm = 3'd3;
    end else if (ad[8]) begin
      norm = 3'd4;
    end else if (ad[9]) begin
      norm = 3'd5;
    end else if (ad[10]) begin
      norm = 3'd6;
    end else if (|ad[11:35]) begin
      norm = 3'd7;
    end else begin
      norm = 3'd0;
    end
  end

endmodule

`default_nettype wire

//--- src/diagApb.sv
`timescale 1ns/100ps
`default_nettype none

`include "irBoard_consts.svh"

module diagApb (
  input  wire logic                   CON,
  input  wire logic                   rstN,
  input  wire irBoard_pkg::apbReq_t    apbIn,
  input  wire logic                   ramGnt,
  input  wire irBoard_pkg::dramEntry_t ramRdata,
  input  wire irBoard_pkg::irState_t   irIn,
  input  wire irBoard_pkg::dramAddr_t  dispAddr,
  input  wire irBoard_pkg::dispatch_t  dispIn,
  input  wire logic                   testSatisfied,
  input  wire logic                   adZero,
  input  wire irBoard_pkg::normCode_t  norm,
  output irBoard_pkg::apbRsp_t        apbOut,
  output irBoard_pkg::diagCtrl_t      ctrl,
  output logic                        ramReq,
  output logic                        ramWrite,
  output irBoard_pkg::dramAddr_t      ramAddr,
  output irBoard_pkg::dramEntry_t     ramWdata
);

  import irBoard_pkg::*;

  logic                       access;
  logic                       window;
  logic                       ctrlHit;
  logic                       diagHit;
  logic                       rdDone;
  logic [`APB_ADDR_WIDTH-1:0] diagOff;
  logic [2:0]                 group;
  logic [5:0]                 diagData;

  assign access  = apbIn.psel & apbIn.penable;
  assign window  = apbIn.paddr[`DRAM_WINDOW_BIT];
  assign ctrlHit = ~window & (apbIn.paddr == `REG_CTRL);
  assign diagOff = apbIn.paddr - `REG_DIAG_BASE;
  assign diagHit = ~window & (apbIn.paddr >= `REG_DIAG_BASE) &
                   (diagOff < `APB_ADDR_WIDTH'(`DIAG_GROUPS * 4));
  assign group   = diagOff[4:2];

  // RAM window request, dropped once read data is back
  assign ramReq   = access & window & ~rdDone;
  assign ramWrite = apbIn.pwrite;
  assign ramAddr  = apbIn.paddr[10:2];
  assign ramWdata = dramEntry_t'(apbIn.pwdata[`DRAM_WIDTH-1:0]);

  always_ff @(posedge CON or negedge rstN) begin
    if (!rstN) begin
      ctrl   <= '0;
      rdDone <= 1'b0;
    end else begin
      if (access && ctrlHit && apbIn.pwrite) begin
        ctrl.enIoJrst <= apbIn.pwdata[0];
        ctrl.enAc     <= apbIn.pwdata[1];
      end
      if (rdDone) begin
        rdDone <= 1'b0;
      end else if (ramGnt && !ramWrite) begin
        rdDone <= 1'b1;
      end
    end
  end

  // Six bit groups of internal state
  always_comb begin
    case (group)
      3'd0:    diagData = {norm, dispAddr[0:2]};
      3'd1:    diagData = dispAddr[3:8];
      3'd2:    diagData = {ctrl.enIoJrst, ctrl.enAc, irIn.irAc};
      3'd3:    diagData = {dispIn.dispA, dispIn.dispB};
      3'd4:    diagData = {testSatisfied, irIn.jrst0, dispIn.dispJ[7:4]};
      3'd5:    diagData = {adZero, dispIn.parityOk, dispIn.dispJ[3:0]};
      default: diagData = '0;
    endcase
  end

  always_comb begin
    apbOut.prdata  = '0;
    apbOut.pslverr = 1'b0;
    if (window) begin
      apbOut.prdata[`DRAM_WIDTH-1:0] = ramRdata;
      // Writes finish on grant, reads one cycle later
      apbOut.pready = access & (ramWrite ? ramGnt : rdDone);
    end else begin
      if (ctrlHit) begin
        apbOut.prdata[1:0] = {ctrl.enAc, ctrl.enIoJrst};
      end else if (diagHit) begin
        apbOut.prdata[5:0] = diagData;
      end
      apbOut.pready = access;
    end
  end

endmodule

`default_nettype wire

//--- src/dispatchRam.sv
`timescale 1ns/100ps
`default_nettype none

`include "irBoard_consts.svh"

module dispatchRam (
  input  wire logic                   CON,
  input  wire logic                   rstN,
  input  wire logic                   loadDram,
  input  wire irBoard_pkg::dramAddr_t  dispAddr,
  input  wire irBoard_pkg::irState_t   irIn,
  input  wire logic                   ramReq,
  input  wire logic                   ramWrite,
  input  wire irBoard_pkg::dramAddr_t  ramAddr,
  input  wire irBoard_pkg::dramEntry_t ramWdata,
  output logic                        ramGnt,
  output irBoard_pkg::dramEntry_t     ramRdata,
  output irBoard_pkg::dispatch_t      dispOut
);

  import irBoard_pkg::*;

  logic [`DRAM_WIDTH-1:0] mem [`DRAM_SIZE];
  logic [`DRAM_WIDTH-1:0] portQ;
  dramAddr_t              portAddr;
  dramEntry_t             rdEntry;

  logic     loadDramQ;
  logic     rdPend;
  logic     validQ;
  logic     jrstS1;
  logic     jrstS2;
  acField_t acS1;
  acField_t acS2;
  logic [2:0] dispAQ;
  logic [2:0] dispBQ;
  logic [7:0] dispJQ;
  logic       parityOkQ;

  // Dispatch read owns the port in the cycle after loadDram
  assign ramGnt   = ramReq & ~loadDramQ;
  assign portAddr = loadDramQ ? dispAddr : ramAddr;

  always_ff @(posedge CON) begin
    if (ramGnt && ramWrite) begin
      mem[ramAddr] <= ramWdata;
    end
    if (loadDramQ || ramGnt) begin
      portQ <= mem[portAddr];
    end
  end

  assign rdEntry  = dramEntry_t'(portQ);
  assign ramRdata = rdEntry;

  always_ff @(posedge CON or negedge rstN) begin
    if (!rstN) begin
      loadDramQ <= 1'b0;
      rdPend    <= 1'b0;
      validQ    <= 1'b0;
    end else begin
      loadDramQ <= loadDram;
      rdPend    <= loadDramQ;
      validQ    <= rdPend;
    end
  end

  // JRST info follows its own load down the pipe
  always_ff @(posedge CON) begin
    if (loadDram) begin
      jrstS1 <= irIn.jrst;
      acS1   <= irIn.ir[9:12];
    end
    if (loadDramQ) begin
      jrstS2 <= jrstS1;
      acS2   <= acS1;
    end
    if (rdPend) begin
      dispAQ    <= rdEntry.dispA;
      dispBQ    <= rdEntry.dispB;
      dispJQ    <= {rdEntry.dispJ[7:4], jrstS2 ? acS2 : rdEntry.dispJ[3:0]};
      // Stored word must have odd parity
      parityOkQ <= ^portQ;
    end
  end

  always_comb begin
    dispOut.dispA    = dispAQ;
    dispOut.dispB    = dispBQ;
    dispOut.dispJ    = dispJQ;
    dispOut.parityOk = parityOkQ;
    dispOut.valid    = validQ;
  end

endmodule

`default_nettype wire

//--- src/irBoard.sv
`timescale 1ns/100ps
`default_nettype none

module irBoard (
  input  wire logic                CON,
  input  wire logic                rstN,
  input  wire logic                loadIr,
  input  wire logic                mbXfer,
  input  wire irBoard_pkg::adWord_t ad,
  input  wire irBoard_pkg::adWord_t cacheData,
  input  wire logic                loadDram,
  input  wire logic                adCarryM2,
  input  wire logic [1:0]          magic,
  input  wire irBoard_pkg::apbReq_t apbIn,
  output irBoard_pkg::apbRsp_t     apbOut,
  output irBoard_pkg::irState_t    irOut,
  output irBoard_pkg::dispatch_t   dispOut,
  output logic                     testSatisfied,
  output logic                     adZero,
  output irBoard_pkg::normCode_t   norm
);

  import irBoard_pkg::*;

  diagCtrl_t  ctrl;
  dramAddr_t  dispAddr;
  logic       ramReq;
  logic       ramWrite;
  logic       ramGnt;
  dramAddr_t  ramAddr;
  dramEntry_t ramWdata;
  dramEntry_t ramRdata;

  irLatch uIrLatch (
    .CON(CON), .rstN(rstN), .loadIr(loadIr), .mbXfer(mbXfer),
    .ad(ad), .cacheData(cacheData), .loadDram(loadDram), .ctrl(ctrl),
    .irOut(irOut), .dispAddr(dispAddr)
  );

  dispatchRam uDispatchRam (
    .CON(CON), .rstN(rstN), .loadDram(loadDram), .dispAddr(dispAddr),
    .irIn(irOut), .ramReq(ramReq), .ramWrite(ramWrite), .ramAddr(ramAddr),
    .ramWdata(ramWdata), .ramGnt(ramGnt), .ramRdata(ramRdata),
    .dispOut(dispOut)
  );

  // Condition logic runs off the latched B field
  condTest uCondTest (
    .ad(ad), .adCarryM2(adCarryM2), .magic(magic), .dispB(dispOut.dispB),
    .testSatisfied(testSatisfied), .adZero(adZero), .norm(norm)
  );

  diagApb uDiagApb (
    .CON(CON), .rstN(rstN), .apbIn(apbIn), .ramGnt(ramGnt),
    .ramRdata(ramRdata), .irIn(irOut), .dispAddr(dispAddr), .dispIn(dispOut),
    .testSatisfied(testSatisfied), .adZero(adZero), .norm(norm),
    .apbOut(apbOut), .ctrl(ctrl), .ramReq(ramReq), .ramWrite(ramWrite),
    .ramAddr(ramAddr), .ramWdata(ramWdata)
  );

endmodule

`default_nettype wire

//--- src/irBoard_pkg.sv
`default_nettype none

`include "irBoard_consts.svh"

package irBoard_pkg;

  // IR side vectors use mainframe numbering, bit 0 is the MSB
  typedef logic [0:`IR_AD_WIDTH-1]    adWord_t;
  typedef logic [0:`IR_FIELD_WIDTH-1] irWord_t;
  typedef logic [0:8]                 opcode_t;
  typedef logic [0:3]                 acField_t;
  typedef logic [0:`DRAM_ADDR_BITS-1] dramAddr_t;
  typedef logic [2:0]                 normCode_t;

  // One stored dispatch word
  typedef struct packed {
    logic [2:0] dispA;
    logic [2:0] dispB;
    logic       parity;
    logic [7:0] dispJ;
  } dramEntry_t;

  typedef struct packed {
    irWord_t  ir;
    acField_t irAc;
    logic     jrst;
    logic     jrst0;
  } irState_t;

  // Decoded dispatch, valid pulses once per load
  typedef struct packed {
    logic [2:0] dispA;
    logic [2:0] dispB;
    logic [7:0] dispJ;
    logic       parityOk;
    logic       valid;
  } dispatch_t;

  typedef struct packed {
    logic enIoJrst;
    logic enAc;
  } diagCtrl_t;

  typedef struct packed {
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [31:0]                pwdata;
  } apbReq_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apbRsp_t;

endpackage

`default_nettype wire

//--- src/irLatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "irBoard_consts.svh"

module irLatch (
  input  wire logic                  CON,
  input  wire logic                  rstN,
  input  wire logic                  loadIr,
  input  wire logic                  mbXfer,
  input  wire irBoard_pkg::adWord_t  ad,
  input  wire irBoard_pkg::adWord_t  cacheData,
  input  wire logic                  loadDram,
  input  wire irBoard_pkg::diagCtrl_t ctrl,
  output irBoard_pkg::irState_t      irOut,
  output irBoard_pkg::dramAddr_t     dispAddr
);

  import irBoard_pkg::*;

  irWord_t   irQ;
  opcode_t   opcode;
  acField_t  acBits;
  logic      ioDispatch;
  logic      ioLegal;
  dramAddr_t nextAddr;

  // Opcode and AC field, taken from the adder on MB transfers
  always_ff @(posedge CON or negedge rstN) begin
    if (!rstN) begin
      irQ <= '0;
    end else if (loadIr) begin
      irQ <= mbXfer ? ad[0:`IR_FIELD_WIDTH-1] : cacheData[0:`IR_FIELD_WIDTH-1];
    end
  end

  assign opcode = irQ[0:8];
  assign acBits = irQ[9:12];

  // 7xx instructions dispatch on device function bits
  assign ioDispatch = ctrl.enIoJrst & (&opcode[0:2]);
  assign ioLegal    = &irQ[3:6];

  always_comb begin
    if (ioDispatch) begin
      nextAddr = {3'b111, irQ[7:9] | {3{ioLegal}}, irQ[10:12]};
    end else begin
      nextAddr = opcode;
    end
  end

  always_ff @(posedge CON or negedge rstN) begin
    if (!rstN) begin
      dispAddr <= '0;
    end else if (loadDram) begin
      dispAddr <= nextAddr;
    end
  end

  always_comb begin
    irOut.ir    = irQ;
    // AC field only visible when enabled from diagnostics
    irOut.irAc  = ctrl.enAc ? acBits : '0;
    irOut.jrst  = (opcode == `JRST_OPCODE);
    irOut.jrst0 = irOut.jrst & (acBits == '0);
  end

endmodule

`default_nettype wire

//--- tb/irBoard_sva.sv
`timescale 1ns/100ps
`default_nettype none

module irBoard_sva (
  input wire logic                   CON,
  input wire logic                   rstN,
  input wire logic                   loadDram,
  input wire logic                   ramGnt,
  input wire irBoard_pkg::apbRsp_t   apbOut,
  input wire irBoard_pkg::dispatch_t dispOut
);

  // Two valid cycles in a row need two loads three and four edges back
  validPair: assert property (@(posedge CON) disable iff (!rstN)
    dispOut.valid && $past(dispOut.valid) |-> $past(loadDram, 3) && $past(loadDram, 4))
    else $error("valid held for two cycles without two loadDram pulses");

  readyAtReset: assert property (@(posedge CON)
    $rose(rstN) |-> !apbOut.pready)
    else $error("pready high when reset released");

  noSlvErr: assert property (@(posedge CON) disable iff (!rstN)
    !apbOut.pslverr)
    else $error("pslverr asserted");

  // Dispatch read owns the RAM port in the cycle after loadDram
  dispatchOwnsPort: assert property (@(posedge CON) disable iff (!rstN)
    $past(loadDram) |-> !ramGnt)
    else $error("APB granted the RAM during a dispatch read");

endmodule

bind irBoard irBoard_sva uSva (
  .CON(CON), .rstN(rstN), .loadDram(loadDram), .ramGnt(ramGnt),
  .apbOut(apbOut), .dispOut(dispOut)
);

`default_nettype wire

//--- tb/irBoard_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "irBoard_consts.svh"

module irBoard_tb;

  import irBoard_pkg::*;

  // Rough cycle count of all tests with margin
  localparam int CYCLE_BUDGET = 2500;

  logic      CON;
  logic      rstN;
  logic      loadIr;
  logic      mbXfer;
  logic      loadDram;
  logic      adCarryM2;
  logic [1:0] magic;
  adWord_t   ad;
  adWord_t   cacheData;
  apbReq_t   apbIn;
  apbRsp_t   apbOut;
  irState_t  irOut;
  dispatch_t dispOut;
  logic      testSatisfied;
  logic      adZero;
  normCode_t norm;

  logic [31:0]            lfsr;
  logic [`DRAM_WIDTH-1:0] shadow [`DRAM_SIZE];
  int        errors;
  int        checks;
  int        testStart;
  int        lastWaits;
  diagCtrl_t ctrlModel;
  irWord_t   irModel;
  dramAddr_t addrModel;
  dispatch_t dispModel;

  irBoard i_dut (
    .CON(CON), .rstN(rstN), .loadIr(loadIr), .mbXfer(mbXfer), .ad(ad),
    .cacheData(cacheData), .loadDram(loadDram), .adCarryM2(adCarryM2),
    .magic(magic), .apbIn(apbIn), .apbOut(apbOut), .irOut(irOut),
    .dispOut(dispOut), .testSatisfied(testSatisfied), .adZero(adZero), .norm(norm)
  );

  always #4 CON = ~CON;

  function automatic logic [35:0] randBits(input int n);
    logic [35:0] r;
    logic fb;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[34:0], fb};
    end
    return r;
  endfunction

  function automatic adWord_t randAd();
    adWord_t r;
    if (randBits(3) == 0) begin
      return '0;
    end
    r = randBits(36);
    return r >> (randBits(6) % 36);
  endfunction

  function automatic dramAddr_t addrRule(input irWord_t ir, input logic io);
    if (io && ir[0:2] == 3'b111) begin
      return {3'b111, (&ir[3:6]) ? 3'b111 : ir[7:9], ir[10:12]};
    end
    return ir[0:8];
  endfunction

  function automatic dispatch_t modelDispatch(input dramEntry_t e, input irWord_t ir);
    dispatch_t d;
    d.dispA    = e.dispA;
    d.dispB    = e.dispB;
    d.dispJ    = {e.dispJ[7:4], (ir[0:8] == `JRST_OPCODE) ? ir[9:12] : e.dispJ[3:0]};
    d.parityOk = ^e;
    d.valid    = 1'b1;
    return d;
  endfunction

  function automatic irState_t expIr(input irWord_t v);
    irState_t s;
    s.ir    = v;
    s.irAc  = ctrlModel.enAc ? v[9:12] : 4'h0;
    s.jrst  = (v[0:8] == `JRST_OPCODE);
    s.jrst0 = s.jrst && (v[9:12] == 4'h0);
    return s;
  endfunction

  function automatic logic condModel(input adWord_t a, input logic [1:0] m,
                                     input logic c, input logic [2:0] b);
    logic zero;
    logic t;
    zero = (a == '0);
    t = (b[1] && zero) || (b[2] && m[0] && !a[0] && !zero) ||
        (b[2] && m[1] && a[0]) || ((m[0] != m[1]) && c);
    return t ^ b[0];
  endfunction

  function automatic normCode_t normModel(input adWord_t a);
    int i;
    for (i = 0; i < 36; i++) begin
      if (a[i]) begin
        if (i == 0) return 3'd1;
        if (i <= 6) return 3'd2;
        if (i <= 10) return 3'(i - 4);
        return 3'd7;
      end
    end
    return 3'd0;
  endfunction

  function automatic logic [5:0] expGroup(input int g);
    irState_t s;
    s = expIr(irModel);
    case (g)
      0: return {normModel(ad), addrModel[0:2]};
      1: return addrModel[3:8];
      2: return {ctrlModel.enIoJrst, ctrlModel.enAc, s.irAc};
      3: return {dispModel.dispA, dispModel.dispB};
      4: return {condModel(ad, magic, adCarryM2, dispModel.dispB), s.jrst0,
                 dispModel.dispJ[7:4]};
      5: return {ad == '0, dispModel.parityOk, dispModel.dispJ[3:0]};
      default: return 6'h0;
    endcase
  endfunction

  task automatic checkEq(input string name, input logic [35:0] got, input logic [35:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finishTest(input string name);
    $display("%s finished with %0d errors", name, errors - testStart);
    testStart = errors;
  endtask

  // Setup then access phase, optional loadDram pulse to collide with it
  task automatic apbXfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
                         input logic collide, output logic [31:0] rdata);
    int waits;
    logic done;
    waits = 0;
    done = 0;
    rdata = '0;
    @(posedge CON);
    apbIn.paddr   <= addr;
    apbIn.pwrite  <= wr;
    apbIn.pwdata  <= wdata;
    apbIn.psel    <= 1'b1;
    apbIn.penable <= 1'b0;
    if (collide) begin
      loadDram <= 1'b1;
      addrModel = addrRule(irModel, ctrlModel.enIoJrst);
    end
    @(posedge CON);
    apbIn.penable <= 1'b1;
    loadDram      <= 1'b0;
    while (!done) begin
      @(negedge CON);
      if (apbOut.pready) begin
        rdata = apbOut.prdata;
        done = 1;
      end else begin
        waits++;
        if (waits > 20) begin
          $display("APB transfer to %h never saw pready", addr);
          errors++;
          done = 1;
        end
      end
      @(posedge CON);
    end
    apbIn.psel    <= 1'b0;
    apbIn.penable <= 1'b0;
    lastWaits = waits;
  endtask

  task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apbXfer(addr, 1'b1, data, 1'b0, unused);
  endtask

  task automatic apbRead(input logic [11:0] addr, output logic [31:0] data);
    apbXfer(addr, 1'b0, 32'h0, 1'b0, data);
  endtask

  task automatic writeCtrl(input logic [1:0] v);
    apbWrite(`REG_CTRL, {30'h0, v});
    ctrlModel.enIoJrst = v[0];
    ctrlModel.enAc     = v[1];
  endtask

  task automatic writeEntry(input dramAddr_t a, input logic [14:0] e, input logic collide);
    logic [31:0] unused;
    apbXfer({1'b1, a, 2'b00}, 1'b1, {17'h0, e}, collide, unused);
    shadow[a] = e;
  endtask

  function automatic logic [14:0] makeEntry(input logic bad);
    logic [14:0] e;
    e = 15'(randBits(15));
    e[8] = ~^{e[14:9], e[7:0]} ^ bad;
    return e;
  endfunction

  task automatic checkGroups(input int lo, input int hi);
    logic [31:0] rd;
    int g;
    for (g = lo; g <= hi; g++) begin
      apbRead(`REG_DIAG_BASE + 12'(g * 4), rd);
      checkEq($sformatf("diag group %0d", g), rd, {26'h0, expGroup(g)});
    end
  endtask

  task automatic loadInstr(input irWord_t v, input logic fromAd);
    adWord_t w;
    w = {v, 23'(randBits(23))};
    @(posedge CON);
    mbXfer <= fromAd;
    if (fromAd) begin
      ad <= w;
    end else begin
      cacheData <= w;
    end
    loadIr <= 1'b1;
    @(posedge CON);
    loadIr <= 1'b0;
    irModel = v;
    @(negedge CON);
    checkEq("irOut", irOut, expIr(v));
  endtask

  task automatic pulseLoad();
    @(posedge CON);
    loadDram <= 1'b1;
    @(posedge CON);
    loadDram <= 1'b0;
    addrModel = addrRule(irModel, ctrlModel.enIoJrst);
  endtask

  // Counts the cycles from the last load edge to the valid pulse
  task automatic waitValid(output dispatch_t got, output int cycles);
    int n;
    n = 0;
    @(negedge CON);
    while (!dispOut.valid && n < 8) begin
      @(negedge CON);
      n++;
    end
    if (!dispOut.valid) begin
      $display("dispatch valid pulse did not arrive");
      errors++;
    end
    got = dispOut;
    cycles = n;
  endtask

  task automatic runDispatch();
    dispatch_t got;
    int lat;
    pulseLoad();
    waitValid(got, lat);
    checkEq("dispatch latency", lat, 2);
    dispModel = modelDispatch(shadow[addrModel], irModel);
    checkEq("dispOut", got, dispModel);
    @(negedge CON);
    checkEq("valid pulse", dispOut.valid, 1'b0);
  endtask

  task automatic testCtrlReadback();
    logic [31:0] rd;
    logic [1:0] v;
    int i;
    for (i = 0; i < 4; i++) begin
      v = 2'(randBits(2));
      writeCtrl(v);
      apbRead(`REG_CTRL, rd);
      checkEq("ctrl", rd, {30'h0, v});
    end
    checkGroups(0, 2);
    checkGroups(6, 7);
    finishTest("control readback");
  endtask

  task automatic testRamWindow();
    logic [31:0] rd;
    dramAddr_t a;
    logic [14:0] e;
    int i;
    for (i = 0; i < 10; i++) begin
      a = 9'(randBits(9));
      e = 15'(randBits(15));
      writeEntry(a, e, i[0]);
      checkEq("write waits", lastWaits, i[0] ? 1 : 0);
      apbXfer({1'b1, a, 2'b00}, 1'b0, 32'h0, i[1], rd);
      checkEq("read waits", lastWaits, i[1] ? 2 : 1);
      checkEq("ram read", rd, {17'h0, e});
    end
    finishTest("dispatch ram window");
  endtask

  task automatic testIrDispatch();
    irWord_t v;
    int i;
    for (i = 0; i < 12; i++) begin
      if (i % 4 == 0) begin
        writeCtrl(2'(randBits(2)));
      end
      v = 13'(randBits(13));
      if (i % 4 == 1) begin
        v[0:8] = `JRST_OPCODE;
      end
      writeEntry(addrRule(v, ctrlModel.enIoJrst), makeEntry(i % 3 == 2), 1'b0);
      loadInstr(v, i[0]);
      runDispatch();
      checkGroups(0, 5);
    end
    finishTest("ir load and dispatch");
  endtask

  task automatic testIoAddress();
    irWord_t v;
    int i;
    for (i = 0; i < 8; i++) begin
      writeCtrl({1'(randBits(1)), i < 4});
      v = 13'(randBits(13));
      v[0:2] = 3'b111;
      if (i[0]) begin
        v[3:6] = 4'hf;
      end
      loadInstr(v, 1'b0);
      pulseLoad();
      checkGroups(0, 1);
    end
    finishTest("io dispatch address");
  endtask

  task automatic testCondition();
    irWord_t v;
    int i;
    int j;
    for (i = 0; i < 6; i++) begin
      v = 13'(randBits(13));
      writeEntry(addrRule(v, ctrlModel.enIoJrst), makeEntry(1'b0), 1'b0);
      loadInstr(v, 1'b0);
      runDispatch();
      for (j = 0; j < 8; j++) begin
        @(posedge CON);
        ad        <= randAd();
        magic     <= 2'(randBits(2));
        adCarryM2 <= 1'(randBits(1));
        @(negedge CON);
        checkEq("testSatisfied", testSatisfied, condModel(ad, magic, adCarryM2, dispModel.dispB));
        checkEq("adZero", adZero, ad == '0);
        checkEq("norm", norm, normModel(ad));
      end
    end
    finishTest("condition and normalize");
  endtask

  task automatic testBackToBack();
    irWord_t vA;
    irWord_t vB;
    dispatch_t expA;
    dispatch_t expB;
    dispatch_t got;
    int lat;
    vA = 13'(randBits(13));
    vB = 13'(randBits(13));
    writeEntry(addrRule(vA, ctrlModel.enIoJrst), makeEntry(1'b0), 1'b0);
    writeEntry(addrRule(vB, ctrlModel.enIoJrst), makeEntry(1'b1), 1'b0);
    expA = modelDispatch(shadow[addrRule(vA, ctrlModel.enIoJrst)], vA);
    expB = modelDispatch(shadow[addrRule(vB, ctrlModel.enIoJrst)], vB);
    @(posedge CON);
    mbXfer    <= 1'b0;
    cacheData <= {vA, 23'h0};
    loadIr    <= 1'b1;
    @(posedge CON);
    cacheData <= {vB, 23'h0};
    loadDram  <= 1'b1;
    @(posedge CON);
    loadIr <= 1'b0;
    @(posedge CON);
    loadDram <= 1'b0;
    irModel   = vB;
    addrModel = addrRule(vB, ctrlModel.enIoJrst);
    dispModel = expB;
    waitValid(got, lat);
    // First load was one edge before the second
    checkEq("first dispatch latency", lat, 1);
    checkEq("first dispOut", got, expA);
    @(negedge CON);
    checkEq("second dispOut", dispOut, expB);
    finishTest("back to back loads");
  endtask

  initial begin
    #(CYCLE_BUDGET * 8);
    $display("watchdog expired before the tests completed");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    CON       = 1'b0;
    rstN      = 1'b0;
    loadIr    = 1'b0;
    mbXfer    = 1'b0;
    loadDram  = 1'b0;
    adCarryM2 = 1'b0;
    magic     = 2'b00;
    ad        = '0;
    cacheData = '0;
    apbIn     = '0;
    lfsr      = 32'h6e45e254;
    errors    = 0;
    checks    = 0;
    testStart = 0;
    ctrlModel = '0;
    irModel   = '0;
    addrModel = '0;
    dispModel = '0;
    repeat (5) @(posedge CON);
    rstN <= 1'b1;

    testCtrlReadback();
    testRamWindow();
    testIrDispatch();
    testIoAddress();
    testCondition();
    testBackToBack();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
